//--- common/isaPkg.sv
package isaPkg;

	localparam int numRegs = 8;

	typedef logic [$clog2(numRegs)-1:0] regIdx_t;

	// Encoding is fixed by the instruction set
	typedef enum logic [3:0] {
		opMov = 4'd0,
		opAdd = 4'd1,
		opSub = 4'd2,
		opMul = 4'd3,
		opOr  = 4'd4,
		opAnd = 4'd5,
		opXor = 4'd6,
		opSl  = 4'd7,
		opSr  = 4'd8,
		opSra = 4'd9,
		opRot = 4'd10,
		opBit = 4'd11,
		opSet = 4'd12,
		opClr = 4'd13,
		opCmp = 4'd14,
		opSex = 4'd15
	} aluOp_e;

	typedef struct packed {
		logic       immFlag;  // 0 in this form
		aluOp_e     op;
		regIdx_t    rd;
		regIdx_t    ra;
		regIdx_t    rb;
		logic [1:0] spare;    // Unused padding
	} regForm_t;

	typedef struct packed {
		logic       immFlag;  // 1 in this form
		aluOp_e     op;
		regIdx_t    rd;
		regIdx_t    ra;
		logic [4:0] imm5;     // Zero-extended to B
	} immForm_t;

	// Bit 15 tells which view is valid
	typedef union packed {
		regForm_t regView;
		immForm_t immView;
	} instrWord_u;

endpackage

//--- common/aluPkg.sv
package aluPkg;

	import isaPkg::*;

	localparam int dataWidth = 16;
	localparam int shiftBits = 4;  // Low bits of B used for shifts and bit ops

	typedef logic [dataWidth-1:0] word_t;

	typedef struct packed {
		logic sign;
		logic carry;
		logic zero;
		logic parity;  // Overflow for arithmetic ops
	} aluFlags_t;

	typedef enum logic {
		classLogic,
		classArith
	} opClass_e;

	// Selects what the parity flag reports
	function automatic opClass_e opClass(input aluOp_e op);
		case (op)
			opAdd, opSub, opMul, opCmp, opSex: return classArith;
			default: return classLogic;
		endcase
	endfunction

endpackage

//--- common/resultIf.sv
`timescale 1ns/100ps

interface resultIf import isaPkg::*, aluPkg::*;;

	logic      valid;   // One-cycle strobe
	aluOp_e    op;
	regIdx_t   dest;
	word_t     result;
	aluFlags_t flags;

	modport exec (
		output valid,
		output op,
		output dest,
		output result,
		output flags
	);

	modport res (
		input valid,
		input op,
		input dest,
		input result,
		input flags
	);

endinterface

//--- core/regFile.sv
`timescale 1ns/100ps

module regFile import isaPkg::*, aluPkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  regIdx_t rdAddrA,
	input  regIdx_t rdAddrB,
	output word_t   rdDataA,
	output word_t   rdDataB,
	input  logic    wrEn,
	input  regIdx_t wrAddr,
	input  word_t   wrData,
	input  logic    loadEn,
	input  regIdx_t loadDest,
	input  word_t   loadData
);

	word_t regs [numRegs];

	always_ff @(posedge clk) begin
		if (rst) begin
			regs <= '{default: '0};
		end else if (wrEn) begin
			regs[wrAddr] <= wrData;       // Pipeline write wins
		end else if (loadEn) begin
			regs[loadDest] <= loadData;
		end
	end

	// Reads are combinational so decode sees them in the issue cycle
	assign rdDataA = regs[rdAddrA];
	assign rdDataB = regs[rdAddrB];

endmodule

//--- core/decodeStage.sv
`timescale 1ns/100ps

module decodeStage import isaPkg::*, aluPkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       instrValid,
	input  instrWord_u instr,
	output regIdx_t    rdAddrA,
	output regIdx_t    rdAddrB,
	input  word_t      rdDataA,
	input  word_t      rdDataB,
	output logic       decValid,
	output aluOp_e     decOp,
	output regIdx_t    decDest,
	output word_t      decA,
	output word_t      decB
);

	logic    useImm;
	aluOp_e  op;
	regIdx_t dest;
	word_t   operandB;

	assign useImm = instr.immView.immFlag;

	// Op, rd and ra sit at the same bits in both forms
	assign op      = instr.regView.op;
	assign dest    = instr.regView.rd;
	assign rdAddrA = instr.regView.ra;

	assign rdAddrB = instr.regView.rb;  // Don't care in immediate form

	assign operandB = useImm ? word_t'(instr.immView.imm5) : rdDataB;

	always_ff @(posedge clk) begin
		if (rst) begin
			decValid <= 1'b0;
		end else begin
			decValid <= instrValid;
		end
	end

	always_ff @(posedge clk) begin
		if (instrValid) begin
			decOp   <= op;
			decDest <= dest;
			decA    <= rdDataA;
			decB    <= operandB;
		end
	end

	// Issuer must present a clean word whenever it strobes
	instrKnown: assert property (@(posedge clk) disable iff (rst)
		instrValid |-> !$isunknown(instr));

endmodule

//--- alu/alu.sv
`timescale 1ns/100ps

module alu import isaPkg::*, aluPkg::*; (
	input  aluOp_e    op,
	input  word_t     argA,
	input  word_t     argB,
	output word_t     result,
	output aluFlags_t flags
);

	logic [shiftBits-1:0]          amt;
	logic [dataWidth:0]            wide;      // Extra bit for carry and borrow
	logic signed [2*dataWidth-1:0] product;
	logic [2*dataWidth-1:0]        rotPair;
	word_t                         bitMask;
	word_t                         sexMask;
	logic                          carry;
	logic                          overflow;

	assign amt     = argB[shiftBits-1:0];
	assign bitMask = word_t'(1) << amt;
	assign sexMask = {dataWidth{1'b1}} << amt;  // Selected bit and above
	assign product = $signed(argA) * $signed(argB);
	assign rotPair = {argA, argA} >> amt;

	always_comb begin
		wide     = '0;
		result   = '0;
		carry    = 1'b0;
		overflow = 1'b0;

		case (op)
			opMov: begin
				result = argB;
			end
			opAdd: begin
				wide   = {1'b0, argA} + {1'b0, argB};
				result = wide[dataWidth-1:0];
				carry  = wide[dataWidth];
			end
			opSub, opCmp: begin
				wide   = {1'b0, argA} - {1'b0, argB};
				result = wide[dataWidth-1:0];
				carry  = wide[dataWidth];          // Borrow
			end
			opMul: begin
				result   = product[dataWidth-1:0];
				overflow = |product[2*dataWidth-1:dataWidth];
			end
			opOr: begin
				result = argA | argB;
			end
			opAnd: begin
				result = argA & argB;
			end
			opXor: begin
				result = argA ^ argB;
			end
			opSl: begin
				wide   = {1'b0, argA} << amt;
				result = wide[dataWidth-1:0];
				carry  = wide[dataWidth];          // Last bit out
			end
			opSr: begin
				result = argA >> amt;
			end
			opSra: begin
				result = $signed(argA) >>> amt;
			end
			opRot: begin
				result = rotPair[dataWidth-1:0];   // Right rotate
			end
			opBit: begin
				result = argA & bitMask;
			end
			opSet: begin
				result = argA | bitMask;
			end
			opClr: begin
				result = argA & ~bitMask;
			end
			opSex: begin
				// Copy the selected bit into everything above it
				if (argA[amt]) begin
					result = argA | sexMask;
				end else begin
					result = argA & ~sexMask;
				end
			end
		endcase

		flags.sign  = result[dataWidth-1];
		flags.carry = carry;
		flags.zero  = (result == '0);
		if (opClass(op) == classArith) begin
			flags.parity = overflow;
		end else begin
			flags.parity = result[0];
		end
	end

endmodule

//--- alu/executeStage.sv
`timescale 1ns/100ps

module executeStage import isaPkg::*, aluPkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  logic    decValid,
	input  aluOp_e  decOp,
	input  regIdx_t decDest,
	input  word_t   decA,
	input  word_t   decB,
	resultIf.exec   res
);

	word_t     aluResult;
	aluFlags_t aluFlags;

	alu i_alu (
		.op     (decOp),
		.argA   (decA),
		.argB   (decB),
		.result (aluResult),
		.flags  (aluFlags)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			res.valid <= 1'b0;
		end else begin
			res.valid <= decValid;
		end
	end

	always_ff @(posedge clk) begin
		if (decValid) begin
			res.op     <= decOp;
			res.dest   <= decDest;
			res.result <= aluResult;
			res.flags  <= aluFlags;
		end
	end

	// Fixed one-cycle hop from decode into the result bus
	validFollows: assert property (@(posedge clk) disable iff (rst)
		decValid |=> res.valid);
	noSpuriousValid: assert property (@(posedge clk) disable iff (rst)
		!decValid |=> !res.valid);

endmodule

//--- core/resultStage.sv
`timescale 1ns/100ps

module resultStage import isaPkg::*, aluPkg::*; (
	input  logic      clk,
	input  logic      rst,
	resultIf.res      res,
	output logic      rfWrEn,
	output regIdx_t   rfWrAddr,
	output word_t     rfWrData,
	output logic      wrValid,
	output regIdx_t   wrDest,
	output word_t     wrData,
	output logic      wrBack,
	output aluFlags_t flags
);

	// CMP only updates flags
	assign rfWrEn   = res.valid && (res.op != opCmp);
	assign rfWrAddr = res.dest;
	assign rfWrData = res.result;

	always_ff @(posedge clk) begin
		if (rst) begin
			wrValid <= 1'b0;
			flags   <= '0;
		end else begin
			wrValid <= res.valid;
			if (res.valid) begin
				flags <= res.flags;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (res.valid) begin
			wrDest <= res.dest;
			wrData <= res.result;
			wrBack <= rfWrEn;
		end
	end

	// A compare never reaches the register file and completes without write-back
	cmpNoWrite: assert property (@(posedge clk) disable iff (rst)
		(res.valid && res.op == opCmp) |-> !rfWrEn ##1 (wrValid && !wrBack));

endmodule

//--- src/aluCore.sv
`timescale 1ns/100ps

module aluCore import isaPkg::*, aluPkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        instrValid,
	input  logic [15:0] instr,
	input  logic        loadEn,
	input  regIdx_t     loadDest,
	input  word_t       loadData,
	output logic        wrValid,
	output regIdx_t     wrDest,
	output word_t       wrData,
	output logic        wrBack,
	output logic [3:0]  flags
);

	regIdx_t rdAddrA;
	regIdx_t rdAddrB;
	word_t   rdDataA;
	word_t   rdDataB;
	logic    rfWrEn;
	regIdx_t rfWrAddr;
	word_t   rfWrData;
	logic    decValid;
	aluOp_e  decOp;
	regIdx_t decDest;
	word_t   decA;
	word_t   decB;

	resultIf resBus ();

	regFile i_regFile (
		.clk      (clk),
		.rst      (rst),
		.rdAddrA  (rdAddrA),
		.rdAddrB  (rdAddrB),
		.rdDataA  (rdDataA),
		.rdDataB  (rdDataB),
		.wrEn     (rfWrEn),
		.wrAddr   (rfWrAddr),
		.wrData   (rfWrData),
		.loadEn   (loadEn),
		.loadDest (loadDest),
		.loadData (loadData)
	);

	decodeStage i_decodeStage (
		.clk        (clk),
		.rst        (rst),
		.instrValid (instrValid),
		.instr      (instr),
		.rdAddrA    (rdAddrA),
		.rdAddrB    (rdAddrB),
		.rdDataA    (rdDataA),
		.rdDataB    (rdDataB),
		.decValid   (decValid),
		.decOp      (decOp),
		.decDest    (decDest),
		.decA       (decA),
		.decB       (decB)
	);

	executeStage i_executeStage (
		.clk      (clk),
		.rst      (rst),
		.decValid (decValid),
		.decOp    (decOp),
		.decDest  (decDest),
		.decA     (decA),
		.decB     (decB),
		.res      (resBus.exec)
	);

	resultStage i_resultStage (
		.clk      (clk),
		.rst      (rst),
		.res      (resBus.res),
		.rfWrEn   (rfWrEn),
		.rfWrAddr (rfWrAddr),
		.rfWrData (rfWrData),
		.wrValid  (wrValid),
		.wrDest   (wrDest),
		.wrData   (wrData),
		.wrBack   (wrBack),
		.flags    (flags)
	);

endmodule

//--- tb/aluChecker.sv
`timescale 1ns/100ps

module aluChecker import isaPkg::*, aluPkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       instrValid,
	input  logic       wrValid,
	input  regIdx_t    wrDest,
	input  word_t      wrData,
	input  logic       wrBack,
	input  logic [3:0] flags,
	output int         errors,
	output int         checks,
	output int         done
);

	typedef struct packed {
		regIdx_t    dest;
		word_t      data;
		logic       back;
		logic [3:0] flg;
	} expect_t;

	localparam int latency = 3;  // Issue edge to wrValid sample

	expect_t expQ[$];
	int      issueQ[$];          // Cycle numbers of sampled instructions
	int      cycle = 0;
	int      errCount = 0;
	int      checkCount = 0;
	int      doneCount = 0;
	logic    rstSeen = 1'b0;

	assign errors = errCount;
	assign checks = checkCount;
	assign done   = doneCount;

	// Called by the stimulus side for each issued instruction
	task automatic expectResult(input regIdx_t dest, input word_t data, input logic back,
		input logic [3:0] flg);
		expect_t e;
		e.dest = dest;
		e.data = data;
		e.back = back;
		e.flg  = flg;
		expQ.push_back(e);
	endtask

	task automatic checkField(input string name, input logic [31:0] got,
		input logic [31:0] want);
		checkCount++;
		if (got !== want) begin
			errCount++;
			$display("** Error: %s got 0x%h expected 0x%h at %0t", name, got, want, $time);
		end
	endtask

	always @(posedge clk) begin
		expect_t e;
		int      issued;
		cycle = cycle + 1;

		// Outputs were cleared by the reset edge before this one
		if (rstSeen) begin
			checkField("wrValid", wrValid, 0);
			checkField("flags", flags, 0);
		end
		rstSeen = rst;

		if (!rst && instrValid === 1'b1) begin
			issueQ.push_back(cycle);
		end

		if (wrValid === 1'b1 && !rstSeen) begin
			if (expQ.size() == 0 || issueQ.size() == 0) begin
				errCount++;
				$display("wrValid pulsed with no instruction outstanding at %0t", $time);
			end else begin
				e      = expQ.pop_front();
				issued = issueQ.pop_front();
				checkField("wrValid latency", cycle - issued, latency);
				checkField("wrDest", wrDest, e.dest);
				checkField("wrData", wrData, e.data);
				checkField("wrBack", wrBack, e.back);
				checkField("flags", flags, e.flg);
				doneCount++;
			end
		end
	end

endmodule

//--- tb/tbAluCore.sv
`timescale 1ns/100ps

module tbAluCore import isaPkg::*, aluPkg::*; ();

	typedef struct packed {
		logic       doReset;  // Drain and reset before the row
		logic       ld;
		regIdx_t    ldReg;
		word_t      ldVal;
		logic       imm;
		aluOp_e     op;
		regIdx_t    rd;
		regIdx_t    ra;
		logic [4:0] bField;   // rb in low bits or imm5
		logic [1:0] gap;      // Idle cycles after issue
		word_t      expData;
		logic       expBack;
		logic [3:0] expFlags; // sign carry zero parity
	} row_t;

	logic       clk;
	logic       rst;
	logic       instrValid;
	logic [15:0] instr;
	logic       loadEn;
	regIdx_t    loadDest;
	word_t      loadData;
	logic       wrValid;
	regIdx_t    wrDest;
	word_t      wrData;
	logic       wrBack;
	logic [3:0] flags;
	int         errors;
	int         checks;
	int         done;
	int         issued = 0;
	logic       tableReady = 1'b0;
	row_t       rows[$];

	aluCore i_aluCore (
		.clk        (clk),
		.rst        (rst),
		.instrValid (instrValid),
		.instr      (instr),
		.loadEn     (loadEn),
		.loadDest   (loadDest),
		.loadData   (loadData),
		.wrValid    (wrValid),
		.wrDest     (wrDest),
		.wrData     (wrData),
		.wrBack     (wrBack),
		.flags      (flags)
	);

	aluChecker i_aluChecker (
		.clk        (clk),
		.rst        (rst),
		.instrValid (instrValid),
		.wrValid    (wrValid),
		.wrDest     (wrDest),
		.wrData     (wrData),
		.wrBack     (wrBack),
		.flags      (flags),
		.errors     (errors),
		.checks     (checks),
		.done       (done)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [15:0] encodeInstr(input logic imm, input aluOp_e op,
		input regIdx_t rd, input regIdx_t ra, input logic [4:0] b);
		if (imm) begin
			return {1'b1, op, rd, ra, b};
		end
		return {1'b0, op, rd, ra, b[2:0], 2'b00};
	endfunction

	task automatic addRow(input logic doReset, input logic ld, input regIdx_t ldReg,
		input word_t ldVal, input logic imm, input aluOp_e op, input regIdx_t rd,
		input regIdx_t ra, input logic [4:0] bField, input logic [1:0] gap,
		input word_t expData, input logic expBack, input logic [3:0] expFlags);
		rows.push_back({doReset, ld, ldReg, ldVal, imm, op, rd, ra, bField, gap,
			expData, expBack, expFlags});
	endtask

	task automatic nextCycle();
		@(posedge clk);
		#2;
	endtask

	task automatic waitIdle();
		while (done != issued) begin
			nextCycle();
		end
	endtask

	task automatic applyRow(input row_t r);
		if (r.doReset) begin
			waitIdle();
			rst = 1'b1;
			repeat (4) nextCycle();
			rst = 1'b0;
		end
		if (r.ld) begin
			waitIdle();            // Preload only with nothing in flight
			loadEn   = 1'b1;
			loadDest = r.ldReg;
			loadData = r.ldVal;
			nextCycle();
			loadEn = 1'b0;
		end
		instr      = encodeInstr(r.imm, r.op, r.rd, r.ra, r.bField);
		instrValid = 1'b1;
		i_aluChecker.expectResult(r.rd, r.expData, r.expBack, r.expFlags);
		issued++;
		nextCycle();
		instrValid = 1'b0;
		repeat (r.gap) nextCycle();
	endtask

	task automatic buildTable();
		// rst ld ldReg ldVal imm op rd ra b gap data back flags
		addRow(0, 1, 1, 'hFFFF, 0, opMov, 7, 0, 1, 0, 'hFFFF, 1, 'h9);
		addRow(0, 1, 2, 'h0001, 0, opAdd, 3, 1, 2, 0, 'h0000, 1, 'h6);
		addRow(0, 0, 0, 'h0000, 0, opSub, 4, 2, 1, 0, 'h0002, 1, 'h4);
		addRow(0, 1, 6, 'h0100, 0, opMul, 5, 6, 6, 0, 'h0000, 1, 'h3);
		addRow(0, 0, 0, 'h0000, 0, opMul, 3, 1, 1, 0, 'h0001, 1, 'h0);
		addRow(0, 0, 0, 'h0000, 0, opMul, 0, 1, 6, 0, 'hFF00, 1, 'h9);
		addRow(0, 0, 0, 'h0000, 0, opCmp, 4, 2, 6, 2, 'hFF01, 0, 'hC);
		addRow(0, 0, 0, 'h0000, 0, opMov, 5, 0, 4, 0, 'h0002, 1, 'h0);
		// Logic ops and immediate MOV
		addRow(0, 1, 2, 'h3C0F, 0, opOr,  3, 2, 6, 0, 'h3D0F, 1, 'h1);
		addRow(0, 0, 0, 'h0000, 0, opAnd, 4, 2, 0, 0, 'h3C00, 1, 'h0);
		addRow(0, 0, 0, 'h0000, 0, opXor, 5, 2, 1, 0, 'hC3F0, 1, 'h8);
		addRow(0, 0, 0, 'h0000, 0, opXor, 7, 2, 2, 0, 'h0000, 1, 'h2);
		addRow(0, 0, 0, 'h0000, 1, opMov, 6, 0, 31, 0, 'h001F, 1, 'h1);
		// Shifts and rotate, r6 holds 31 for the wide amount
		addRow(0, 1, 1, 'hC001, 1, opSl,  3, 1, 1, 0, 'h8002, 1, 'hC);
		addRow(0, 0, 0, 'h0000, 1, opSl,  4, 1, 0, 0, 'hC001, 1, 'h9);
		addRow(0, 0, 0, 'h0000, 1, opSl,  5, 1, 15, 0, 'h8000, 1, 'h8);
		addRow(0, 0, 0, 'h0000, 1, opSr,  7, 1, 15, 0, 'h0001, 1, 'h1);
		addRow(0, 0, 0, 'h0000, 1, opSra, 0, 1, 4, 0, 'hFC00, 1, 'h8);
		addRow(0, 0, 0, 'h0000, 1, opRot, 2, 1, 4, 0, 'h1C00, 1, 'h0);
		addRow(0, 0, 0, 'h0000, 0, opSr,  4, 1, 6, 0, 'h0001, 1, 'h1);
		addRow(0, 0, 0, 'h0000, 1, opSl,  5, 1, 17, 0, 'h8002, 1, 'hC);
		addRow(0, 0, 0, 'h0000, 1, opSra, 3, 1, 15, 0, 'hFFFF, 1, 'h9);
		// Bit ops and sign extension
		addRow(0, 1, 1, 'h00A5, 1, opBit, 2, 1, 0, 0, 'h0001, 1, 'h1);
		addRow(0, 0, 0, 'h0000, 1, opBit, 3, 1, 1, 0, 'h0000, 1, 'h2);
		addRow(0, 0, 0, 'h0000, 1, opSet, 4, 1, 15, 0, 'h80A5, 1, 'h9);
		addRow(0, 0, 0, 'h0000, 1, opClr, 5, 1, 2, 0, 'h00A1, 1, 'h1);
		addRow(0, 0, 0, 'h0000, 1, opSet, 7, 1, 20, 0, 'h00B5, 1, 'h1);
		addRow(0, 0, 0, 'h0000, 1, opSex, 0, 1, 7, 0, 'hFFA5, 1, 'h8);
		addRow(0, 0, 0, 'h0000, 1, opSex, 6, 1, 6, 0, 'h0025, 1, 'h0);
		// Dependent pair after two idle cycles, then back to back
		addRow(0, 1, 2, 'h1234, 1, opAdd, 3, 2, 1, 2, 'h1235, 1, 'h0);
		addRow(0, 0, 0, 'h0000, 1, opAdd, 3, 3, 2, 0, 'h1237, 1, 'h0);
		addRow(0, 0, 0, 'h0000, 1, opXor, 4, 2, 31, 0, 'h122B, 1, 'h1);
		addRow(0, 0, 0, 'h0000, 1, opSub, 5, 2, 4, 0, 'h1230, 1, 'h0);
		addRow(0, 0, 0, 'h0000, 1, opOr,  7, 0, 0, 0, 'hFFA5, 1, 'h9);
		// Registers read back as zero after reset
		addRow(1, 0, 0, 'h0000, 0, opMov, 1, 0, 3, 0, 'h0000, 1, 'h2);
		addRow(0, 0, 0, 'h0000, 0, opAdd, 2, 5, 7, 0, 'h0000, 1, 'h2);
	endtask

	initial begin
		rst        = 1'b1;
		instrValid = 1'b0;
		instr      = '0;
		loadEn     = 1'b0;
		loadDest   = '0;
		loadData   = '0;
		buildTable();
		tableReady = 1'b1;
		repeat (4) @(posedge clk);
		#2;
		rst = 1'b0;
		foreach (rows[i]) begin
			applyRow(rows[i]);
		end
		waitIdle();
		repeat (3) nextCycle();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// Watchdog sized from the table length
	initial begin
		wait (tableReady);
		repeat (rows.size() * 8 + 100) @(posedge clk);
		$display("Timeout: the run did not complete, %0d of %0d results seen", done, issued);
		$display("TEST FAILED");
		$finish;
	end

endmodule

//--- sources.f
common/isaPkg.sv
common/aluPkg.sv
common/resultIf.sv
core/regFile.sv
core/decodeStage.sv
alu/alu.sv
alu/executeStage.sv
core/resultStage.sv
src/aluCore.sv
tb/aluChecker.sv
tb/tbAluCore.sv
